//--- all.f
+incdir+hw
hw/irq_periph_pkg.sv
hw/bus_decoder.sv
hw/sync_fifo.sv
hw/clint_timer.sv
hw/plic_lite.sv
hw/periph_regs.sv
hw/irq_periph_top.sv
tb/tb_irq_periph.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_irq_periph
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run check clean

all: check

$(OBJ_DIR)/V%: $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)

check: run
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/tb_irq_periph.sv
`timescale 1ns/1ps
`default_nettype none
`include "irq_periph_defines.svh"

module tb_irq_periph
    import irq_periph_pkg::*;
();

    localparam int TIMEOUT = 50;

    localparam logic [31:0] MSIP_A   = `IRQP_CLINT_BASE + 32'(`IRQP_MSIP_OFS);
    localparam logic [31:0] CMP_LO_A = `IRQP_CLINT_BASE + 32'(`IRQP_MTIMECMP_OFS);
    localparam logic [31:0] CMP_HI_A = CMP_LO_A + 32'd4;
    localparam logic [31:0] MTIME_A  = `IRQP_CLINT_BASE + 32'(`IRQP_MTIME_OFS);
    localparam logic [31:0] PEND_A   = `IRQP_PLIC_BASE + 32'(`IRQP_PENDING_OFS);

    logic                         clk_i = 1'b0;
    logic                         ndmreset_n;
    logic                         req_i;
    host_req_t                    req_data_i;
    logic                         req_full_o;
    logic                         rsp_pop_i;
    logic                         rsp_valid_o;
    host_rsp_t                    rsp_o;
    logic [`IRQP_NUM_SOURCES-1:0] irq_sources_i;
    logic                         timer_irq_o;
    logic                         ipi_o;
    logic [`IRQP_NUM_TARGETS-1:0] eip_o;

    logic [15:0] lfsr_q = 16'd81;
    string       test_name;
    int          err_count = 0;
    int          start_errs = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;

    irq_periph_top u_dut (
        .clk_i         ( clk_i         ),
        .ndmreset_n    ( ndmreset_n    ),
        .req_i         ( req_i         ),
        .req_data_i    ( req_data_i    ),
        .req_full_o    ( req_full_o    ),
        .rsp_pop_i     ( rsp_pop_i     ),
        .rsp_valid_o   ( rsp_valid_o   ),
        .rsp_o         ( rsp_o         ),
        .irq_sources_i ( irq_sources_i ),
        .timer_irq_o   ( timer_irq_o   ),
        .ipi_o         ( ipi_o         ),
        .eip_o         ( eip_o         )
    );

    always #10 clk_i = ~clk_i;

    // ----------------------------------------
    reset_values: assert property (@(posedge clk_i) $rose(ndmreset_n) |->
        (!rsp_valid_o && !req_full_o && !timer_irq_o && !ipi_o && eip_o == '0))
        else begin
            $display("outputs were not at their reset values after reset");
            err_count++;
        end

    // A queued response stays until the host pops it
    rsp_held: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        rsp_valid_o && !rsp_pop_i |=> rsp_valid_o)
        else begin
            $display("a response was lost before it was popped");
            err_count++;
        end

    // ----------------------------------------
    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [31:0] enable_addr(input int t);
        return `IRQP_PLIC_BASE + 32'(`IRQP_ENABLE_OFS) + 32'(t) * 32'(`IRQP_ENABLE_STRIDE);
    endfunction

    function automatic logic [31:0] claim_addr(input int t);
        return `IRQP_PLIC_BASE + 32'(`IRQP_CLAIM_OFS) + 32'(t) * 32'(`IRQP_CLAIM_STRIDE);
    endfunction

    // Scan upward, first hit is the winner
    function automatic logic [31:0] lowest_claim(input logic [31:0] bits);
        logic [31:0] id;
        id = 32'd0;
        for (int i = 0; i < 32; i++) begin
            if (bits[i] && id == 32'd0) begin
                id = 32'(i + 1);
            end
        end
        return id;
    endfunction

    task automatic begin_test(input string name);
        test_name  = name;
        start_errs = err_count;
    endtask

    task automatic end_test();
        if (err_count == start_errs) begin
            pass_cnt++;
            $display("test %s: passed", test_name);
        end else begin
            fail_cnt++;
            $display("test %s: failed", test_name);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
            err_count++;
        end
    endtask

    task automatic check_above(input string what, input logic [31:0] floor,
                               input logic [31:0] act);
        assert (act > floor) else begin
            $display("error %s %s: expected above %h, actual %h", test_name, what, floor, act);
            err_count++;
        end
    endtask

    // ----------------------------------------
    // Host side
    task automatic wait_rsp(output logic ok);
        int n;
        n = 0;
        @(posedge clk_i);
        while (!rsp_valid_o && n < TIMEOUT) begin
            @(posedge clk_i);
            n++;
        end
        ok = rsp_valid_o;
    endtask

    task automatic pop_rsp();
        rsp_pop_i <= 1'b1;
        @(posedge clk_i);
        rsp_pop_i <= 1'b0;
    endtask

    task automatic issue_request(input logic is_write, input logic [31:0] addr,
                                 input logic [31:0] wdata);
        @(posedge clk_i);
        req_i      <= 1'b1;
        req_data_i <= '{we: is_write, addr: addr, wdata: wdata};
        @(posedge clk_i);
        req_i <= 1'b0;
    endtask

    task automatic bus_access(input logic is_write, input logic [31:0] addr,
                              input logic [31:0] wdata, output host_rsp_t rsp);
        logic ok;
        issue_request(is_write, addr, wdata);
        wait_rsp(ok);
        if (ok) begin
            rsp = rsp_o;
            pop_rsp();
        end else begin
            rsp = '0;
            $display("no response for address %h within %0d cycles", addr, TIMEOUT);
            err_count++;
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] wdata);
        host_rsp_t rsp;
        bus_access(1'b1, addr, wdata, rsp);
        check_value("write err", 32'd0, 32'(rsp.err));
        check_value("write rdata", 32'd0, rsp.rdata);
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] rdata);
        host_rsp_t rsp;
        bus_access(1'b0, addr, 32'd0, rsp);
        check_value("read err", 32'd0, 32'(rsp.err));
        rdata = rsp.rdata;
    endtask

    task automatic wait_irq(input int which, input logic level);
        int   n;
        logic cur;
        n   = 0;
        cur = ~level;
        while (cur !== level && n < TIMEOUT) begin
            @(posedge clk_i);
            cur = (which == 0) ? timer_irq_o : ipi_o;
            n++;
        end
        assert (cur === level) else begin
            $display("%s interrupt did not reach level %0d within %0d cycles",
                     (which == 0) ? "timer" : "software", level, TIMEOUT);
            err_count++;
        end
    endtask

    // ----------------------------------------
    task automatic mtime_advance();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] third;
        begin_test("mtime");
        read_reg(MTIME_A, first);
        repeat (10) @(posedge clk_i);
        read_reg(MTIME_A, second);
        check_above("second read", first, second);
        // Read-only, keeps counting
        write_reg(MTIME_A, 32'd0);
        read_reg(MTIME_A, third);
        check_above("read after write", second, third);
        end_test();
    endtask

    task automatic timer_interrupt();
        begin_test("timer");
        write_reg(CMP_LO_A, 32'd0);
        write_reg(CMP_HI_A, 32'd0);
        wait_irq(0, 1'b1);
        write_reg(CMP_HI_A, 32'hFFFF_FFFF);
        write_reg(CMP_LO_A, 32'hFFFF_FFFF);
        wait_irq(0, 1'b0);
        end_test();
    endtask

    task automatic software_interrupt();
        logic [31:0] v;
        begin_test("msip");
        write_reg(MSIP_A, 32'd1);
        wait_irq(1, 1'b1);
        read_reg(MSIP_A, v);
        check_value("msip set", 32'd1, v);
        write_reg(MSIP_A, 32'd0);
        wait_irq(1, 1'b0);
        read_reg(MSIP_A, v);
        check_value("msip clear", 32'd0, v);
        end_test();
    endtask

    task automatic plic_gating();
        logic [31:0] src;
        logic [31:0] mask;
        logic [31:0] v;
        logic [31:0] en [2];
        logic [1:0]  exp_eip;
        begin_test("plic");
        for (int i = 0; i < 6; i++) begin
            draw_bits(32, src);
            draw_bits(32, en[0]);
            draw_bits(32, en[1]);
            // Sparse patterns so claims land on higher indices
            if (i % 2 == 1) begin
                draw_bits(32, mask);
                src   = src & mask;
                en[0] = en[0] & mask;
            end
            if (i == 2) begin
                en[1] = 32'd0;
            end
            if (i == 4) begin
                src = 32'd0;
            end
            @(posedge clk_i);
            irq_sources_i <= src;
            write_reg(enable_addr(0), en[0]);
            write_reg(enable_addr(1), en[1]);
            read_reg(PEND_A, v);
            check_value("pending", src, v);
            for (int t = 0; t < 2; t++) begin
                exp_eip[t] = |(src & en[t]);
            end
            check_value("eip", 32'(exp_eip), 32'(eip_o));
            for (int t = 0; t < 2; t++) begin
                read_reg(claim_addr(t), v);
                check_value("claim", lowest_claim(src & en[t]), v);
            end
        end
        end_test();
    endtask

    task automatic decode_errors();
        logic [31:0] bad_addr [8];
        host_rsp_t   rsp;
        begin_test("decode");
        bad_addr[0] = 32'h0000_0000;
        bad_addr[1] = `IRQP_CLINT_BASE - 32'd4;
        bad_addr[2] = `IRQP_CLINT_BASE + `IRQP_CLINT_LEN;
        bad_addr[3] = `IRQP_PLIC_BASE - 32'd4;
        bad_addr[4] = `IRQP_PLIC_BASE + `IRQP_PLIC_LEN;
        bad_addr[5] = 32'hFFFF_FFFC;
        // Inside a window but not a register
        bad_addr[6] = `IRQP_CLINT_BASE + 32'h0000_0100;
        bad_addr[7] = `IRQP_PLIC_BASE + 32'h0000_0010;
        for (int i = 0; i < 8; i++) begin
            bus_access(i % 2 == 1, bad_addr[i], 32'hA5A5_5A5A, rsp);
            check_value("err", 32'd1, 32'(rsp.err));
            check_value("rdata", 32'd0, rsp.rdata);
        end
        end_test();
    endtask

    task automatic backpressure_order();
        logic [31:0] model_en [2];
        logic [31:0] val;
        logic        is_wr;
        logic        ok;
        host_rsp_t   exp;
        host_rsp_t   expq [$];
        int          issued;
        int          got;
        int          t;
        begin_test("backpressure");
        model_en[0] = 32'd0;
        model_en[1] = 32'd0;
        issued      = 0;
        // Groups of two enable writes, then reads of the same two
        while (!req_full_o && issued < 16) begin
            draw_bits(32, val);
            t     = issued % 2;
            is_wr = (issued % 4) < 2;
            exp.err = 1'b0;
            if (is_wr) begin
                model_en[t] = val;
                exp.rdata   = 32'd0;
            end else begin
                exp.rdata = model_en[t];
            end
            issue_request(is_wr, enable_addr(t), val);
            expq.push_back(exp);
            issued++;
            // Let the decoder push land before looking at full
            @(posedge clk_i);
            @(posedge clk_i);
        end
        assert (req_full_o) else begin
            $display("request FIFO never filled while responses were held back");
            err_count++;
        end
        check_value("requests accepted", 32'(2 * `IRQP_FIFO_DEPTH), 32'(issued));
        got = 0;
        while (expq.size() > 0) begin
            wait_rsp(ok);
            if (!ok) begin
                $display("response %0d of %0d never arrived", got, issued);
                err_count++;
                break;
            end
            exp = expq.pop_front();
            check_value("rdata", exp.rdata, rsp_o.rdata);
            check_value("err", 32'(exp.err), 32'(rsp_o.err));
            pop_rsp();
            got++;
        end
        @(posedge clk_i);
        @(posedge clk_i);
        check_value("valid after drain", 32'd0, 32'(rsp_valid_o));
        check_value("full after drain", 32'd0, 32'(req_full_o));
        check_value("responses", 32'(issued), 32'(got));
        end_test();
    endtask

    // ----------------------------------------
    initial begin
        ndmreset_n    <= 1'b0;
        req_i         <= 1'b0;
        req_data_i    <= '0;
        rsp_pop_i     <= 1'b0;
        irq_sources_i <= '0;
        repeat (3) @(posedge clk_i);
        ndmreset_n <= 1'b1;

        mtime_advance();
        timer_interrupt();
        software_interrupt();
        plic_gating();
        decode_errors();
        backpressure_order();

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/irq_periph_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "irq_periph_defines.svh"

module irq_periph_top
    import irq_periph_pkg::*;
(
    input  wire logic                         clk_i,
    input  wire logic                         ndmreset_n,
    input  wire logic                         req_i,
    input  wire host_req_t                    req_data_i,
    output logic                              req_full_o,
    input  wire logic                         rsp_pop_i,
    output logic                              rsp_valid_o,
    output host_rsp_t                         rsp_o,
    input  wire logic [`IRQP_NUM_SOURCES-1:0] irq_sources_i,
    output logic                              timer_irq_o,
    output logic                              ipi_o,
    output logic      [`IRQP_NUM_TARGETS-1:0] eip_o
);

    logic      dec_push;
    dec_req_t  dec_req;
    logic      req_valid;
    dec_req_t  req_head;
    logic      req_pop;
    logic      rsp_push;
    host_rsp_t rsp_data;
    logic      rsp_full;

    bus_decoder u_bus_decoder (
        .clk_i      ( clk_i      ),
        .ndmreset_n ( ndmreset_n ),
        .req_i      ( req_i      ),
        .req_data_i ( req_data_i ),
        .push_o     ( dec_push   ),
        .dec_o      ( dec_req    )
    );

    sync_fifo #(
        .payload_t ( dec_req_t        ),
        .DEPTH     ( `IRQP_FIFO_DEPTH )
    ) u_req_fifo (
        .clk_i       ( clk_i      ),
        .ndmreset_n  ( ndmreset_n ),
        .push_i      ( dec_push   ),
        .data_i      ( dec_req    ),
        .pop_i       ( req_pop    ),
        .data_o      ( req_head   ),
        .not_empty_o ( req_valid  ),
        .full_o      ( req_full_o )
    );

    periph_regs u_periph_regs (
        .clk_i         ( clk_i         ),
        .ndmreset_n    ( ndmreset_n    ),
        .req_valid_i   ( req_valid     ),
        .req_i         ( req_head      ),
        .req_pop_o     ( req_pop       ),
        .rsp_full_i    ( rsp_full      ),
        .rsp_push_o    ( rsp_push      ),
        .rsp_o         ( rsp_data      ),
        .irq_sources_i ( irq_sources_i ),
        .timer_irq_o   ( timer_irq_o   ),
        .ipi_o         ( ipi_o         ),
        .eip_o         ( eip_o         )
    );

    sync_fifo #(
        .payload_t ( host_rsp_t       ),
        .DEPTH     ( `IRQP_FIFO_DEPTH )
    ) u_rsp_fifo (
        .clk_i       ( clk_i       ),
        .ndmreset_n  ( ndmreset_n  ),
        .push_i      ( rsp_push    ),
        .data_i      ( rsp_data    ),
        .pop_i       ( rsp_pop_i   ),
        .data_o      ( rsp_o       ),
        .not_empty_o ( rsp_valid_o ),
        .full_o      ( rsp_full    )
    );

    // Host holds off while the request FIFO is full
    assert property (@(posedge clk_i) disable iff (!ndmreset_n) req_i |-> !req_full_o)
        else $error("irq_periph_top: request issued while request FIFO full");

endmodule

`default_nettype wire

//--- hw/periph_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "irq_periph_defines.svh"

module periph_regs
    import irq_periph_pkg::*;
(
    input  wire logic                         clk_i,
    input  wire logic                         ndmreset_n,
    input  wire logic                         req_valid_i,
    input  wire dec_req_t                     req_i,
    output logic                              req_pop_o,
    input  wire logic                         rsp_full_i,
    output logic                              rsp_push_o,
    output host_rsp_t                         rsp_o,
    input  wire logic [`IRQP_NUM_SOURCES-1:0] irq_sources_i,
    output logic                              timer_irq_o,
    output logic                              ipi_o,
    output logic      [`IRQP_NUM_TARGETS-1:0] eip_o
);

    logic  clint_we;
    logic  plic_we;
    data_t clint_rdata;
    data_t plic_rdata;
    logic  clint_hit;
    logic  plic_hit;
    logic  blk_hit;
    data_t blk_rdata;

    // One entry per cycle while there is room for its response
    assign req_pop_o  = req_valid_i && !rsp_full_i;
    assign rsp_push_o = req_pop_o;

    assign clint_we = req_pop_o && req_i.we && (req_i.tgt == TGT_CLINT);
    assign plic_we  = req_pop_o && req_i.we && (req_i.tgt == TGT_PLIC);

    clint_timer u_clint_timer (
        .clk_i       ( clk_i        ),
        .ndmreset_n  ( ndmreset_n   ),
        .we_i        ( clint_we     ),
        .offset_i    ( req_i.offset ),
        .wdata_i     ( req_i.wdata  ),
        .rdata_o     ( clint_rdata  ),
        .hit_o       ( clint_hit    ),
        .timer_irq_o ( timer_irq_o  ),
        .ipi_o       ( ipi_o        )
    );

    plic_lite u_plic_lite (
        .clk_i         ( clk_i         ),
        .ndmreset_n    ( ndmreset_n    ),
        .we_i          ( plic_we       ),
        .offset_i      ( req_i.offset  ),
        .wdata_i       ( req_i.wdata   ),
        .rdata_o       ( plic_rdata    ),
        .hit_o         ( plic_hit      ),
        .irq_sources_i ( irq_sources_i ),
        .eip_o         ( eip_o         )
    );

    always_comb begin
        case (req_i.tgt)
            TGT_CLINT: begin
                blk_hit   = clint_hit;
                blk_rdata = clint_rdata;
            end
            TGT_PLIC: begin
                blk_hit   = plic_hit;
                blk_rdata = plic_rdata;
            end
            default: begin
                blk_hit   = 1'b0;
                blk_rdata = '0;
            end
        endcase
        // Writes and misses carry no data
        rsp_o.err   = !blk_hit;
        rsp_o.rdata = (blk_hit && !req_i.we) ? blk_rdata : '0;
    end

    // msip only moves on a routed CLINT write
    assert property (@(posedge clk_i) disable iff (!ndmreset_n)
        $changed(ipi_o) |-> $past(clint_we))
        else $error("periph_regs: ipi changed without a CLINT write");

endmodule

`default_nettype wire

//--- hw/plic_lite.sv
`timescale 1ns/1ps
`default_nettype none
`include "irq_periph_defines.svh"

module plic_lite
    import irq_periph_pkg::*;
(
    input  wire logic                         clk_i,
    input  wire logic                         ndmreset_n,
    input  wire logic                         we_i,
    input  wire ofs_t                         offset_i,
    input  wire data_t                        wdata_i,
    output data_t                             rdata_o,
    output logic                              hit_o,
    input  wire logic [`IRQP_NUM_SOURCES-1:0] irq_sources_i,
    output logic      [`IRQP_NUM_TARGETS-1:0] eip_o
);

    localparam int NS = `IRQP_NUM_SOURCES;
    localparam int NT = `IRQP_NUM_TARGETS;

    logic [NS-1:0]         pending_q;
    logic [NT-1:0][NS-1:0] enable_q;
    data_t                 claim_id [NT];

    function automatic ofs_t enable_ofs(input int t);
        return `IRQP_ENABLE_OFS + ofs_t'(t) * `IRQP_ENABLE_STRIDE;
    endfunction

    function automatic ofs_t claim_ofs(input int t);
        return `IRQP_CLAIM_OFS + ofs_t'(t) * `IRQP_CLAIM_STRIDE;
    endfunction

    // Level sources, pending just follows them
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            pending_q <= '0;
            enable_q  <= '0;
        end else begin
            pending_q <= irq_sources_i;
            for (int t = 0; t < NT; t++) begin
                if (we_i && offset_i == enable_ofs(t)) begin
                    enable_q[t] <= wdata_i[NS-1:0];
                end
            end
        end
    end

    // Lowest enabled pending source wins
    always_comb begin
        for (int t = 0; t < NT; t++) begin
            eip_o[t]    = |(pending_q & enable_q[t]);
            claim_id[t] = '0;
            for (int s = NS - 1; s >= 0; s--) begin
                if (pending_q[s] && enable_q[t][s]) begin
                    claim_id[t] = data_t'(s + 1);
                end
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        hit_o   = 1'b0;
        if (offset_i == `IRQP_PENDING_OFS) begin
            hit_o   = 1'b1;
            rdata_o = data_t'(pending_q);
        end
        for (int t = 0; t < NT; t++) begin
            if (offset_i == enable_ofs(t)) begin
                hit_o   = 1'b1;
                rdata_o = data_t'(enable_q[t]);
            end
            if (offset_i == claim_ofs(t)) begin
                hit_o   = 1'b1;
                rdata_o = claim_id[t];
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none
`include "irq_periph_defines.svh"

module clint_timer
    import irq_periph_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  ndmreset_n,
    input  wire logic  we_i,
    input  wire ofs_t  offset_i,
    input  wire data_t wdata_i,
    output data_t      rdata_o,
    output logic       hit_o,
    output logic       timer_irq_o,
    output logic       ipi_o
);

    localparam ofs_t MSIP      = `IRQP_MSIP_OFS;
    localparam ofs_t CMP_LO    = `IRQP_MTIMECMP_OFS;
    localparam ofs_t CMP_HI    = `IRQP_MTIMECMP_OFS + ofs_t'(4);
    localparam ofs_t MTIME_LO  = `IRQP_MTIME_OFS;
    localparam ofs_t MTIME_HI  = `IRQP_MTIME_OFS + ofs_t'(4);

    logic        rtc_q;
    logic        rtc_d_q;
    logic        rtc_rise;
    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        msip_q;

    // ----------------------------------------
    // rtc at half the clock rate
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            rtc_q   <= 1'b0;
            rtc_d_q <= 1'b0;
        end else begin
            rtc_q   <= ~rtc_q;
            rtc_d_q <= rtc_q;
        end
    end

    assign rtc_rise = rtc_q & ~rtc_d_q;

    // ----------------------------------------
    // mtime is read-only from the bus
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;
            msip_q     <= 1'b0;
        end else begin
            if (rtc_rise) begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (we_i && offset_i == MSIP) begin
                msip_q <= wdata_i[0];
            end
            if (we_i && offset_i == CMP_LO) begin
                mtimecmp_q[31:0] <= wdata_i;
            end
            if (we_i && offset_i == CMP_HI) begin
                mtimecmp_q[63:32] <= wdata_i;
            end
        end
    end

    always_comb begin
        rdata_o = '0;
        hit_o   = 1'b1;
        case (offset_i)
            MSIP:     rdata_o = data_t'(msip_q);
            CMP_LO:   rdata_o = mtimecmp_q[31:0];
            CMP_HI:   rdata_o = mtimecmp_q[63:32];
            MTIME_LO: rdata_o = mtime_q[31:0];
            MTIME_HI: rdata_o = mtime_q[63:32];
            default:  hit_o   = 1'b0;
        endcase
    end

    assign timer_irq_o = (mtime_q >= mtimecmp_q);
    assign ipi_o       = msip_q;

endmodule

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire logic     clk_i,
    input  wire logic     ndmreset_n,
    input  wire logic     push_i,
    input  wire payload_t data_i,
    input  wire logic     pop_i,
    output payload_t      data_o,
    output logic          not_empty_o,
    output logic          full_o
);

    localparam int AW = $clog2(DEPTH);

    payload_t      mem_q [DEPTH];
    logic [AW-1:0] wptr_q;
    logic [AW-1:0] rptr_q;
    logic [AW:0]   count_q;

    assign data_o      = mem_q[rptr_q];
    assign not_empty_o = (count_q != '0);
    assign full_o      = (count_q == (AW + 1)'(DEPTH));

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wptr_q] <= data_i;
        end
    end

    // Pointers wrap naturally, DEPTH is a power of two
    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            wptr_q  <= '0;
            rptr_q  <= '0;
            count_q <= '0;
        end else begin
            if (push_i) begin
                wptr_q <= wptr_q + 1'b1;
            end
            if (pop_i) begin
                rptr_q <= rptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ----------------------------------------
    assert property (@(posedge clk_i) disable iff (!ndmreset_n) push_i |-> !full_o)
        else $error("sync_fifo: push while full");
    assert property (@(posedge clk_i) disable iff (!ndmreset_n) pop_i |-> not_empty_o)
        else $error("sync_fifo: pop while empty");

endmodule

`default_nettype wire

//--- hw/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "irq_periph_defines.svh"

module bus_decoder
    import irq_periph_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      ndmreset_n,
    input  wire logic      req_i,
    input  wire host_req_t req_data_i,
    output logic           push_o,
    output dec_req_t       dec_o
);

    localparam int OW = `IRQP_OFS_W;

    logic     clint_hit;
    logic     plic_hit;
    dec_req_t dec_d;

    // Windows are [base, base + len)
    assign clint_hit = (req_data_i.addr >= `IRQP_CLINT_BASE) &&
                       (req_data_i.addr <  `IRQP_CLINT_BASE + `IRQP_CLINT_LEN);
    assign plic_hit  = (req_data_i.addr >= `IRQP_PLIC_BASE) &&
                       (req_data_i.addr <  `IRQP_PLIC_BASE + `IRQP_PLIC_LEN);

    always_comb begin
        dec_d.we    = req_data_i.we;
        dec_d.wdata = req_data_i.wdata;
        if (clint_hit) begin
            dec_d.tgt    = TGT_CLINT;
            dec_d.offset = OW'(req_data_i.addr - `IRQP_CLINT_BASE);
        end else if (plic_hit) begin
            dec_d.tgt    = TGT_PLIC;
            dec_d.offset = OW'(req_data_i.addr - `IRQP_PLIC_BASE);
        end else begin
            dec_d.tgt    = TGT_NONE;
            dec_d.offset = '0;
        end
    end

    always_ff @(posedge clk_i or negedge ndmreset_n) begin
        if (!ndmreset_n) begin
            push_o <= 1'b0;
        end else begin
            push_o <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i) begin
            dec_o <= dec_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/irq_periph_pkg.sv
`default_nettype none
`include "irq_periph_defines.svh"

package irq_periph_pkg;

    typedef logic [`IRQP_OFS_W-1:0]  ofs_t;
    typedef logic [`IRQP_DATA_W-1:0] data_t;

    typedef enum logic [1:0] {
        TGT_CLINT = 2'd0,
        TGT_PLIC  = 2'd1,
        TGT_NONE  = 2'd2
    } periph_tgt_e;

    // As issued by the host
    typedef struct packed {
        logic                    we;
        logic [`IRQP_ADDR_W-1:0] addr;
        data_t                   wdata;
    } host_req_t;

    // Offset is relative to the window base
    typedef struct packed {
        logic        we;
        periph_tgt_e tgt;
        ofs_t        offset;
        data_t       wdata;
    } dec_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } host_rsp_t;

endpackage

`default_nettype wire

//--- hw/irq_periph_defines.svh
`ifndef IRQ_PERIPH_DEFINES_SVH
`define IRQ_PERIPH_DEFINES_SVH

// Bus widths
`define IRQP_ADDR_W         32
`define IRQP_DATA_W         32
`define IRQP_OFS_W          26

// Address map
`define IRQP_CLINT_BASE     32'h0200_0000
`define IRQP_CLINT_LEN      32'h0000_C000
`define IRQP_PLIC_BASE      32'h0C00_0000
`define IRQP_PLIC_LEN       32'h0400_0000

// CLINT offsets, 64-bit registers have the high word at +4
`define IRQP_MSIP_OFS       26'h000_0000
`define IRQP_MTIMECMP_OFS   26'h000_4000
`define IRQP_MTIME_OFS      26'h000_BFF8

// PLIC offsets
`define IRQP_PENDING_OFS    26'h000_1000
`define IRQP_ENABLE_OFS     26'h000_2000
`define IRQP_ENABLE_STRIDE  26'h000_0080
`define IRQP_CLAIM_OFS      26'h020_0004
`define IRQP_CLAIM_STRIDE   26'h000_1000

`define IRQP_NUM_SOURCES    32
`define IRQP_NUM_TARGETS    2
`define IRQP_FIFO_DEPTH     4

`endif
